// File: cpu_core.f
logic/cpu_pkg.sv
logic/register_file.sv
logic/alu.sv
logic/control_sequencer.sv
logic/cpu_core.sv
verif/cpu_core_tb.sv

// File: logic/alu.sv
`timescale 1ns/10ps

module alu import cpu_pkg::*;
(
    input  instr_t                instr,
    input  logic [DATA_WIDTH-1:0] operand_a,
    input  logic [DATA_WIDTH-1:0] operand_b,
    input  logic                  flag_a,
    input  logic                  flag_b,
    output alu_result_t           alu_out
);

    logic                  carry_in;
    logic [DATA_WIDTH:0]   sum;
    logic [DATA_WIDTH:0]   diff;
    logic [DATA_WIDTH:0]   shifted;
    logic [DATA_WIDTH-1:0] logic_res;
    logic                  less;

    assign carry_in = (instr.opcode == OP_ADC) ? flag_a : 1'b0;

    // extra top bit holds carry, borrow or the last bit shifted out
    assign sum     = {1'b0, operand_a} + {1'b0, operand_b} + {{DATA_WIDTH{1'b0}}, carry_in};
    assign diff    = {1'b0, operand_a} - {1'b0, operand_b};
    assign shifted = {1'b0, operand_a} << operand_b[4:0];
    assign less    = operand_a < operand_b;

    assign logic_res = (instr.opcode == OP_AND) ? (operand_a & operand_b) :
                       (instr.opcode == OP_OR)  ? (operand_a | operand_b) :
                                                  (operand_a ^ operand_b);

    always_comb
    begin
        alu_out        = '0;
        alu_out.target = instr.value;

        case (instr.opcode)
            OP_ADD, OP_ADC:
            begin
                alu_out.result    = sum[DATA_WIDTH-1:0];
                alu_out.flag      = sum[DATA_WIDTH];
                alu_out.write_reg = 1'b1;
            end
            OP_SUB:
            begin
                alu_out.result    = diff[DATA_WIDTH-1:0];
                alu_out.flag      = diff[DATA_WIDTH];
                alu_out.write_reg = 1'b1;
            end
            OP_AND, OP_OR, OP_XOR:
            begin
                alu_out.result    = logic_res;
                alu_out.flag      = ~|logic_res;
                alu_out.write_reg = 1'b1;
            end
            OP_SHL:
            begin
                alu_out.result    = shifted[DATA_WIDTH-1:0];
                alu_out.flag      = shifted[DATA_WIDTH];
                alu_out.write_reg = 1'b1;
            end
            OP_CMPLT:
            begin
                alu_out.result    = {{(DATA_WIDTH-1){1'b0}}, less};
                alu_out.flag      = less;
                alu_out.write_reg = 1'b1;
            end
            OP_LDI:
            begin
                // merge immediate into one half of a, flag cleared
                if (instr.high_low)
                    alu_out.result = {instr.value, operand_a[15:0]};
                else
                    alu_out.result = {operand_a[31:16], instr.value};
                alu_out.write_reg = 1'b1;
            end
            OP_BRF:
            begin
                alu_out.take_branch = flag_a;
            end
            OP_JMP:
            begin
                alu_out.take_branch = 1'b1;
            end
            default:
            begin
                // loads, stores and unknown codes compute nothing here
                alu_out.result = '0;
            end
        endcase
    end

endmodule

// File: logic/control_sequencer.sv
`timescale 1ns/10ps

module control_sequencer import cpu_pkg::*;
#(
    parameter int ADDR_WIDTH = 16
)
(
    input  logic                  clock,
    input  logic                  reset,

    output logic [ADDR_WIDTH-1:0] mem_address,
    input  logic [DATA_WIDTH-1:0] mem_read_data,
    output logic [DATA_WIDTH-1:0] mem_write_data,
    output logic                  mem_write,

    input  alu_result_t           alu_out,
    input  logic [DATA_WIDTH-1:0] operand_a,
    output instr_t                instr,

    output logic                  reg_write,
    output logic [DATA_WIDTH-1:0] write_data,
    output logic                  write_flag
);

    seq_state_t            state;
    seq_state_t            state_next;
    logic [ADDR_WIDTH-1:0] pc;
    logic [DATA_WIDTH-1:0] load_buf;
    alu_result_t           alu_q;
    logic                  is_load;
    logic                  is_mem;

    assign is_load = instr.opcode == OP_LOAD;
    assign is_mem  = is_load || (instr.opcode == OP_STORE);

    always_comb
    begin
        case (state)
            S_FETCH:     state_next = S_EXECUTE;
            S_EXECUTE:   state_next = S_WRITEBACK;
            default:     state_next = S_FETCH;
        endcase
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            state <= S_FETCH;
            pc    <= '0;
            instr <= '0;
        end
        else
        begin
            state <= state_next;
            if (state == S_FETCH)
                instr <= mem_read_data;
            if (state == S_WRITEBACK)
                pc <= alu_q.take_branch ? ADDR_WIDTH'(alu_q.target) : pc + ADDR_WIDTH'(1);
        end
    end

    // hold execute results so writeback sees stable values
    always_ff @(posedge clock)
    begin
        if (state == S_EXECUTE)
        begin
            alu_q <= alu_out;
            if (is_load)
                load_buf <= mem_read_data;
        end
    end

    // data access uses the immediate as address, otherwise the bus shows the pc
    assign mem_address    = (state == S_EXECUTE && is_mem) ? ADDR_WIDTH'(instr.value) : pc;
    assign mem_write_data = operand_a;
    assign mem_write      = (state == S_EXECUTE) && (instr.opcode == OP_STORE);

    assign reg_write  = (state == S_WRITEBACK) && (alu_q.write_reg || is_load);
    assign write_data = is_load ? load_buf : alu_q.result;
    assign write_flag = is_load ? 1'b0 : alu_q.flag;

    // a store strobe always sits one cycle after its fetch
    assert property (@(posedge clock) disable iff (reset)
        mem_write |-> state == S_EXECUTE && $past(state) == S_FETCH)
    else
        $error("control_sequencer: mem_write outside execute");

    assert property (@(posedge clock) disable iff (reset)
        state inside {S_FETCH, S_EXECUTE, S_WRITEBACK})
    else
        $error("control_sequencer: illegal state encoding");

endmodule

// File: logic/cpu_core.sv
`timescale 1ns/10ps

module cpu_core import cpu_pkg::*;
#(
    parameter int ADDR_WIDTH = 16
)
(
    input  logic                  clock,
    input  logic                  reset,

    output logic [ADDR_WIDTH-1:0] mem_address,
    input  logic [DATA_WIDTH-1:0] mem_read_data,
    output logic [DATA_WIDTH-1:0] mem_write_data,
    output logic                  mem_write
);

    instr_t                instr;
    alu_result_t           alu_out;
    logic [DATA_WIDTH-1:0] operand_a;
    logic [DATA_WIDTH-1:0] operand_b;
    logic                  flag_a;
    logic                  flag_b;
    logic                  reg_write;
    logic [DATA_WIDTH-1:0] write_data;
    logic                  write_flag;

    control_sequencer #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) sequencer_i (
        .clock          (clock),
        .reset          (reset),
        .mem_address    (mem_address),
        .mem_read_data  (mem_read_data),
        .mem_write_data (mem_write_data),
        .mem_write      (mem_write),
        .alu_out        (alu_out),
        .operand_a      (operand_a),
        .instr          (instr),
        .reg_write      (reg_write),
        .write_data     (write_data),
        .write_flag     (write_flag)
    );

    // destination still comes from the instruction register during writeback
    register_file regs_i (
        .clock        (clock),
        .reset        (reset),
        .read_a       (instr.src_a),
        .read_b       (instr.src_b),
        .operand_a    (operand_a),
        .operand_b    (operand_b),
        .flag_a       (flag_a),
        .flag_b       (flag_b),
        .write_enable (reg_write),
        .write_index  (instr.dest),
        .write_data   (write_data),
        .write_flag   (write_flag)
    );

    alu alu_i (
        .instr     (instr),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .flag_a    (flag_a),
        .flag_b    (flag_b),
        .alu_out   (alu_out)
    );

endmodule

// File: logic/cpu_pkg.sv
package cpu_pkg;

    // fixed by the instruction format
    localparam int DATA_WIDTH = 32;

    // code 0 is left unassigned so a cleared instruction register is a no-operation
    typedef enum logic [5:0] {
        OP_ADD   = 6'd1,
        OP_ADC   = 6'd2,
        OP_SUB   = 6'd3,
        OP_AND   = 6'd4,
        OP_OR    = 6'd5,
        OP_XOR   = 6'd6,
        OP_SHL   = 6'd7,
        OP_CMPLT = 6'd8,
        OP_LDI   = 6'd9,
        OP_LOAD  = 6'd10,
        OP_STORE = 6'd11,
        OP_BRF   = 6'd12,
        OP_JMP   = 6'd13
    } opcode_t;

    typedef logic [2:0] reg_index_t;

    // instruction word, most significant field first
    // src_a and src_b also pick the first and second flag
    typedef struct packed {
        logic [15:0] value;
        logic        high_low;
        reg_index_t  dest;
        reg_index_t  src_b;
        reg_index_t  src_a;
        opcode_t     opcode;
    } instr_t;

    typedef enum logic [1:0] {
        S_FETCH     = 2'd0,
        S_EXECUTE   = 2'd1,
        S_WRITEBACK = 2'd2
    } seq_state_t;

    // everything the alu decides for one instruction
    typedef struct packed {
        logic [DATA_WIDTH-1:0] result;
        logic                  flag;
        logic                  write_reg;
        logic                  take_branch;
        logic [15:0]           target;
    } alu_result_t;

endpackage

// File: logic/register_file.sv
`timescale 1ns/10ps

module register_file import cpu_pkg::*;
(
    input  logic                  clock,
    input  logic                  reset,

    input  reg_index_t            read_a,
    input  reg_index_t            read_b,
    output logic [DATA_WIDTH-1:0] operand_a,
    output logic [DATA_WIDTH-1:0] operand_b,
    output logic                  flag_a,
    output logic                  flag_b,

    input  logic                  write_enable,
    input  reg_index_t            write_index,
    input  logic [DATA_WIDTH-1:0] write_data,
    input  logic                  write_flag
);

    logic [DATA_WIDTH-1:0] regs [8];
    logic [7:0]            flags;

    // a register and its flag always change together
    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            for (int i = 0; i < 8; i++)
            begin
                regs[i] <= '0;
            end
            flags <= '0;
        end
        else if (write_enable)
        begin
            regs[write_index]  <= write_data;
            flags[write_index] <= write_flag;
        end
    end

    // combinational read, a write shows up after the writeback edge
    always_comb
    begin
        operand_a = regs[read_a];
        operand_b = regs[read_b];
        flag_a    = flags[read_a];
        flag_b    = flags[read_b];
    end

    // destination comes straight from the instruction register in the sequencer
    assert property (@(posedge clock) disable iff (reset)
        write_enable |-> !$isunknown(write_index))
    else
        $error("register_file: write with unknown index");

endmodule

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert --top-module cpu_core_tb -f cpu_core.f -o cpu_core_sim \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/cpu_core_sim > sim.log 2>&1
cat sim.log
grep -q '\*\*\* TEST PASSED \*\*\*' sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: verif/cpu_core_tb.sv
`timescale 1ns/10ps

module cpu_core_tb import cpu_pkg::*;
();

    localparam int INSTRS          = 400;
    localparam int NUM_PROGRAMS    = 6;
    localparam int RESET_CYCLES    = 8;
    localparam int WATCHDOG_CYCLES = (3 * INSTRS + 2 * (RESET_CYCLES + 1)) * NUM_PROGRAMS + 100;

    localparam int KIND_ARITH = 0;
    localparam int KIND_LOGIC = 1;
    localparam int KIND_LOAD  = 2;
    localparam int KIND_MIXED = 3;
    localparam int KIND_DUMP  = 4;

    logic        clock;
    logic        reset;
    logic [15:0] mem_address;
    logic [31:0] mem_read_data;
    logic [31:0] mem_write_data;
    logic        mem_write;
    logic        load_request;

    // memory seen by the dut, and the model's own copy
    logic [31:0] mem [1024];
    logic [31:0] model_mem [1024];
    logic [31:0] model_regs [8];
    logic [7:0]  model_flags;
    logic [15:0] model_pc;

    integer seed;
    int     gen_pos;

    cpu_core #(
        .ADDR_WIDTH (16)
    ) dut_i (
        .clock          (clock),
        .reset          (reset),
        .mem_address    (mem_address),
        .mem_read_data  (mem_read_data),
        .mem_write_data (mem_write_data),
        .mem_write      (mem_write)
    );

    initial
    begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    assign mem_read_data = mem[mem_address[9:0]];

    // a new program is copied in while the core sits in reset
    always @(posedge clock)
    begin
        if (load_request)
        begin
            for (int i = 0; i < 1024; i++)
                mem[i] <= model_mem[i];
        end
        else if (mem_write)
            mem[mem_address[9:0]] <= mem_write_data;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("ERROR: watchdog expired after %0d cycles, the core stopped responding",
                 WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $fatal(1, "timeout");
    end

    function automatic logic [31:0] random_word();
        return $random(seed);
    endfunction

    // load and store addresses stay in words 256 to 511
    function automatic logic [15:0] data_addr();
        return 16'(32'd256 + (random_word() & 32'd255));
    endfunction

    function automatic logic [31:0] encode_instr(input logic [5:0] op, input logic [2:0] a,
                                                 input logic [2:0] b, input logic [2:0] d,
                                                 input logic high_low, input logic [15:0] value);
        return {value, high_low, d, b, a, op};
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
        else
        begin
            $display("FAIL %s: expected %08h, actual %08h", name, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic put_word(input logic [31:0] word);
        model_mem[gen_pos] = word;
        gen_pos++;
    endtask

    task automatic build_program(input int kind);
        logic [5:0]  arith_ops [5];
        logic [5:0]  logic_ops [4];
        logic [5:0]  op;
        logic [2:0]  d;
        logic [15:0] value;
        arith_ops = '{OP_ADD, OP_ADC, OP_SUB, OP_SHL, OP_CMPLT};
        logic_ops = '{OP_AND, OP_OR, OP_XOR, OP_LDI};
        gen_pos   = 0;
        for (int i = 0; i < 1024; i++)
            model_mem[i] = {i[15:0] ^ 16'hc3a5, ~i[15:0]};
        for (int i = 256; i < 512; i++)
            model_mem[i] = random_word();
        // random start value in every register
        if (kind != KIND_DUMP)
        begin
            for (int r = 0; r < 8; r++)
            begin
                put_word(encode_instr(OP_LDI, 3'(r), 3'd0, 3'(r), 1'b0, 16'(random_word())));
                put_word(encode_instr(OP_LDI, 3'(r), 3'd0, 3'(r), 1'b1, 16'(random_word())));
            end
        end
        if (kind == KIND_MIXED)
        begin
            while (gen_pos < 255)
            begin
                op = 6'(random_word() % 32'd16);
                if (op == OP_LOAD || op == OP_STORE)
                    value = data_addr();
                else if (op == OP_BRF || op == OP_JMP)
                    value = 16'(random_word() % 32'd255);
                else
                    value = 16'(random_word());
                put_word(encode_instr(op, 3'(random_word()), 3'(random_word()),
                                      3'(random_word()), 1'(random_word()), value));
            end
        end
        else if (kind == KIND_DUMP)
        begin
            for (int r = 0; r < 8; r++)
                put_word(encode_instr(OP_STORE, 3'(r), 3'd0, 3'd0, 1'b0, 16'(256 + r)));
            // with a cleared register, r + r + flag leaves just the flag
            for (int r = 0; r < 8; r++)
            begin
                put_word(encode_instr(OP_ADC, 3'(r), 3'(r), 3'(r), 1'b0, 16'd0));
                put_word(encode_instr(OP_STORE, 3'(r), 3'd0, 3'd0, 1'b0, 16'(264 + r)));
            end
            put_word(encode_instr(OP_JMP, 3'd0, 3'd0, 3'd0, 1'b0, 16'd24));
        end
        else
        begin
            // operation, store of d, then r7 = d + d + flag puts the flag in bit 0
            while (gen_pos < 251)
            begin
                d = 3'(random_word());
                if (kind == KIND_ARITH)
                    op = arith_ops[3'(random_word() % 32'd5)];
                else if (kind == KIND_LOGIC)
                    op = logic_ops[2'(random_word() % 32'd4)];
                else
                    op = OP_LOAD;
                value = (op == OP_LOAD) ? data_addr() : 16'(random_word());
                put_word(encode_instr(op, 3'(random_word()), 3'(random_word()), d,
                                      1'(random_word()), value));
                put_word(encode_instr(OP_STORE, d, 3'd0, 3'd0, 1'b0, data_addr()));
                put_word(encode_instr(OP_ADC, d, d, 3'd7, 1'b0, 16'd0));
                put_word(encode_instr(OP_STORE, 3'd7, 3'd0, 3'd0, 1'b0, data_addr()));
            end
        end
        while (gen_pos < 255)
            put_word(32'd0);
        // the last program word wraps back to the start
        model_mem[255] = encode_instr(OP_JMP, 3'd0, 3'd0, 3'd0, 1'b0, 16'd0);
    endtask

    // one instruction of the instruction-set model
    task automatic execute_model(input logic [31:0] word, output logic exp_store,
                                 output logic [15:0] exp_addr, output logic [31:0] exp_data);
        logic [5:0]  op;
        logic [2:0]  a;
        logic [2:0]  b;
        logic [2:0]  d;
        logic [15:0] value;
        logic [31:0] ra;
        logic [31:0] rb;
        logic [31:0] result;
        logic        flag;
        logic        write;
        logic [15:0] next_pc;
        op      = word[5:0];
        a       = word[8:6];
        b       = word[11:9];
        d       = word[14:12];
        value   = word[31:16];
        ra      = model_regs[a];
        rb      = model_regs[b];
        result  = 32'd0;
        flag    = 1'b0;
        next_pc = model_pc + 16'd1;
        write   = op inside {OP_ADD, OP_ADC, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL,
                             OP_CMPLT, OP_LDI, OP_LOAD};
        case (op)
            OP_ADD:   {flag, result} = {1'b0, ra} + {1'b0, rb};
            OP_ADC:   {flag, result} = {1'b0, ra} + {1'b0, rb} + {32'd0, model_flags[a]};
            OP_SUB:   {flag, result} = {1'b0, ra} - {1'b0, rb};
            OP_AND:   result = ra & rb;
            OP_OR:    result = ra | rb;
            OP_XOR:   result = ra ^ rb;
            OP_SHL:   {flag, result} = 33'({32'd0, ra} << rb[4:0]);
            OP_CMPLT: {flag, result} = {ra < rb, 31'd0, ra < rb};
            OP_LDI:   result = word[15] ? {value, ra[15:0]} : {ra[31:16], value};
            OP_LOAD:  result = model_mem[value[9:0]];
            OP_STORE: model_mem[value[9:0]] = ra;
            OP_BRF:   next_pc = model_flags[a] ? value : next_pc;
            OP_JMP:   next_pc = value;
            default:  result = 32'd0;
        endcase
        if (op inside {OP_AND, OP_OR, OP_XOR})
            flag = (result == 32'd0);
        if (write)
        begin
            model_regs[d]  = result;
            model_flags[d] = flag;
        end
        exp_store = (op == OP_STORE);
        exp_addr  = value;
        exp_data  = ra;
        model_pc  = next_pc;
    endtask

    task automatic run_instructions(input string name, input int count);
        logic        exp_store;
        logic [15:0] exp_addr;
        logic [31:0] exp_data;
        repeat (count)
        begin
            @(negedge clock);
            check_value({name, " fetch address"}, 32'(model_pc), 32'(mem_address));
            check_value({name, " strobe in fetch"}, 32'd0, 32'(mem_write));
            execute_model(model_mem[model_pc[9:0]], exp_store, exp_addr, exp_data);
            @(negedge clock);
            check_value({name, " strobe in execute"}, 32'(exp_store), 32'(mem_write));
            if (exp_store)
            begin
                check_value({name, " store address"}, 32'(exp_addr), 32'(mem_address));
                check_value({name, " store data"}, exp_data, mem_write_data);
            end
            @(negedge clock);
            check_value({name, " strobe in writeback"}, 32'd0, 32'(mem_write));
        end
    endtask

    task automatic reset_dut(input int kind);
        @(posedge clock);
        reset <= 1'b1;
        repeat (RESET_CYCLES - 1)
        begin
            @(posedge clock);
            @(negedge clock);
            check_value("reset strobe", 32'd0, 32'(mem_write));
            check_value("reset address", 32'd0, 32'(mem_address));
        end
        build_program(kind);
        load_request = 1'b1;
        @(posedge clock);
        reset        <= 1'b0;
        load_request <= 1'b0;
        for (int r = 0; r < 8; r++)
            model_regs[r] = 32'd0;
        model_flags = 8'd0;
        model_pc    = 16'd0;
    endtask

    initial
    begin
        seed         = 39847;
        reset        = 1'b1;
        load_request = 1'b0;
        reset_dut(KIND_ARITH);
        run_instructions("arithmetic", INSTRS);
        reset_dut(KIND_LOGIC);
        run_instructions("logic", INSTRS);
        reset_dut(KIND_LOAD);
        run_instructions("load", INSTRS);
        reset_dut(KIND_MIXED);
        run_instructions("mixed 1", INSTRS);
        reset_dut(KIND_MIXED);
        run_instructions("mixed 2", INSTRS);
        // reset in the middle of a program, then dump every register and flag
        reset_dut(KIND_MIXED);
        run_instructions("before reset", INSTRS / 2);
        reset_dut(KIND_DUMP);
        run_instructions("after reset", INSTRS / 2);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule
